// ==== dbg_pkg.sv ====
package dbg_pkg;

    // debug module interface
    localparam int ABITS = 7;

    typedef logic [ABITS-1:0] dmaddr_t;
    typedef logic [31:0]      dmdata_t;
    typedef logic [1:0]       dmi_op_t;

    localparam dmi_op_t DMI_NOP   = 2'd0;
    localparam dmi_op_t DMI_READ  = 2'd1;
    localparam dmi_op_t DMI_WRITE = 2'd2;

    // address, data, op
    localparam int W_DMI = ABITS + 34;

    typedef logic [4:0] ir_t;

    localparam ir_t IR_IDCODE = 5'h01;
    localparam ir_t IR_DTMCS  = 5'h10;
    localparam ir_t IR_DMI    = 5'h11;
    localparam ir_t IR_BYPASS = 5'h1f;

    // system bus
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    localparam dmaddr_t A_DMCONTROL  = 7'h10;
    localparam dmaddr_t A_DMSTATUS   = 7'h11;
    localparam dmaddr_t A_SBCS       = 7'h38;
    localparam dmaddr_t A_SBADDRESS0 = 7'h39;
    localparam dmaddr_t A_SBDATA0    = 7'h3c;

    typedef enum logic [3:0] {
        TEST_LOGIC_RESET, RUN_TEST_IDLE,
        SELECT_DR, CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPDATE_DR,
        SELECT_IR, CAPTURE_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
    } tap_state_t;

endpackage

// ==== jtag_dtm.sv ====
`timescale 1ns/1ps

module jtag_dtm #(
    parameter logic [31:0] IDCODE = 32'h1d6a_0001
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             tck,
    input  logic             tms,
    input  logic             tdi,
    output logic             tdo,
    output logic             dmi_req,
    output dbg_pkg::dmaddr_t dmi_addr,
    output dbg_pkg::dmi_op_t dmi_op,
    output dbg_pkg::dmdata_t dmi_wdata,
    input  dbg_pkg::dmdata_t dmi_rdata
);
    import dbg_pkg::*;

    // idle 1, dmistat 0, abits, version 1
    localparam dmdata_t DTMCS = {17'd0, 3'd1, 2'd0, 6'(ABITS), 4'd1};

    logic [2:0]       tck_sr;
    logic [1:0]       tms_sr;
    logic [1:0]       tdi_sr;
    logic             tck_rise;
    logic             tck_fall;
    tap_state_t       tap_state;
    tap_state_t       tap_next;
    ir_t              ir;
    ir_t              ir_shift;
    logic [W_DMI-1:0] dr;
    dmdata_t          dmi_result;
    logic             dmi_req_d;
    logic             dr_update;

    // two sync flops plus a third for edge detection
    always_ff @(posedge clk) begin
        tms_sr <= {tms_sr[0], tms};
        tdi_sr <= {tdi_sr[0], tdi};
        if (rst) begin
            tck_sr <= '0;
        end else begin
            tck_sr <= {tck_sr[1:0], tck};
        end
    end

    assign tck_rise = tck_sr[1] & ~tck_sr[2];
    assign tck_fall = ~tck_sr[1] & tck_sr[2];

    always_comb begin
        case (tap_state)
            TEST_LOGIC_RESET: tap_next = tms_sr[1] ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    tap_next = tms_sr[1] ? SELECT_DR : RUN_TEST_IDLE;
            SELECT_DR:        tap_next = tms_sr[1] ? SELECT_IR : CAPTURE_DR;
            CAPTURE_DR:       tap_next = tms_sr[1] ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         tap_next = tms_sr[1] ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         tap_next = tms_sr[1] ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         tap_next = tms_sr[1] ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         tap_next = tms_sr[1] ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        tap_next = tms_sr[1] ? SELECT_DR : RUN_TEST_IDLE;
            SELECT_IR:        tap_next = tms_sr[1] ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       tap_next = tms_sr[1] ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         tap_next = tms_sr[1] ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         tap_next = tms_sr[1] ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         tap_next = tms_sr[1] ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         tap_next = tms_sr[1] ? UPDATE_IR : SHIFT_IR;
            default:          tap_next = tms_sr[1] ? SELECT_DR : RUN_TEST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tap_state <= TEST_LOGIC_RESET;
        end else if (tck_rise) begin
            tap_state <= tap_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || tap_state == TEST_LOGIC_RESET) begin
            ir <= IR_IDCODE;
        end else if (tck_rise && tap_next == UPDATE_IR) begin
            ir <= ir_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (tck_rise && tap_state == CAPTURE_IR) begin
            ir_shift <= ir_t'(1);
        end else if (tck_rise && tap_state == SHIFT_IR) begin
            ir_shift <= {tdi_sr[1], ir_shift[$bits(ir_t)-1:1]};
        end
    end

    // data register shifts in at the msb of the selected length
    always_ff @(posedge clk) begin
        if (tck_rise && tap_state == CAPTURE_DR) begin
            case (ir)
                IR_IDCODE: dr <= W_DMI'(IDCODE);
                IR_DTMCS:  dr <= W_DMI'(DTMCS);
                IR_DMI:    dr <= {dmi_addr, dmi_result, 2'b00};
                default:   dr <= '0;
            endcase
        end else if (tck_rise && tap_state == SHIFT_DR) begin
            case (ir)
                IR_IDCODE, IR_DTMCS: dr <= {{(W_DMI-32){1'b0}}, tdi_sr[1], dr[31:1]};
                IR_DMI:              dr <= {tdi_sr[1], dr[W_DMI-1:1]};
                default:             dr <= {{(W_DMI-1){1'b0}}, tdi_sr[1]};
            endcase
        end
    end

    assign dr_update = tck_rise && tap_next == UPDATE_DR && ir == IR_DMI &&
                       (dr[1:0] == DMI_READ || dr[1:0] == DMI_WRITE);

    always_ff @(posedge clk) begin
        if (rst) begin
            dmi_req   <= 1'b0;
            dmi_req_d <= 1'b0;
        end else begin
            dmi_req   <= dr_update;
            dmi_req_d <= dmi_req;
        end
    end

    always_ff @(posedge clk) begin
        if (dr_update) begin
            dmi_addr  <= dr[W_DMI-1:34];
            dmi_wdata <= dr[33:2];
            dmi_op    <= dr[1:0];
        end
        // response arrives one cycle after the strobe
        if (dmi_req_d) begin
            dmi_result <= dmi_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tdo <= 1'b0;
        end else if (tck_fall) begin
            tdo <= (tap_state == SHIFT_IR) ? ir_shift[0] : dr[0];
        end
    end

endmodule

// ==== dm_regs.sv ====
`timescale 1ns/1ps

module dm_regs (
    input  logic             clk,
    input  logic             rst,
    input  logic             dmi_req,
    input  dbg_pkg::dmaddr_t dmi_addr,
    input  dbg_pkg::dmi_op_t dmi_op,
    input  dbg_pkg::dmdata_t dmi_wdata,
    output dbg_pkg::dmdata_t dmi_rdata,
    output logic             mem_req,
    output logic             mem_we,
    output dbg_pkg::addr_t   mem_addr,
    output dbg_pkg::data_t   mem_wdata,
    input  dbg_pkg::data_t   mem_rdata
);
    import dbg_pkg::*;

    logic        dmactive;
    logic [19:0] hartsel;
    logic        sbreadonaddr;
    logic        sbbusy;
    logic        sb_pend;
    addr_t       sbaddress0;
    data_t       sbdata0;
    dmdata_t     rdata_mux;
    logic        dmi_write;
    logic        sb_start_wr;
    logic        sb_start_rd;

    assign dmi_write   = dmi_req && dmi_op == DMI_WRITE;
    assign sb_start_wr = dmi_write && dmi_addr == A_SBDATA0;
    assign sb_start_rd = dmi_write && dmi_addr == A_SBADDRESS0 && sbreadonaddr;

    // sbcs reads sbversion 1 and sbaccess 2 (32 bit)
    always_comb begin
        case (dmi_addr)
            A_DMCONTROL:  rdata_mux = {6'd0, hartsel, 5'd0, dmactive};
            A_DMSTATUS:   rdata_mux = 32'd2;
            A_SBCS:       rdata_mux = {3'd1, 7'd0, sbbusy, sbreadonaddr, 3'd2, 17'd0};
            A_SBADDRESS0: rdata_mux = sbaddress0;
            A_SBDATA0:    rdata_mux = sbdata0;
            default:      rdata_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (dmi_req) begin
            dmi_rdata <= rdata_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dmactive     <= 1'b0;
            hartsel      <= '0;
            sbreadonaddr <= 1'b0;
        end else if (dmi_write && dmi_addr == A_DMCONTROL) begin
            dmactive <= dmi_wdata[0];
            hartsel  <= dmi_wdata[25:6];
        end else if (dmi_write && dmi_addr == A_SBCS) begin
            sbreadonaddr <= dmi_wdata[20];
        end
    end

    always_ff @(posedge clk) begin
        if (dmi_write && dmi_addr == A_SBADDRESS0) begin
            sbaddress0 <= dmi_wdata;
        end
        // read data from the bus wins over a dmi write
        if (sb_pend && !mem_we) begin
            sbdata0 <= mem_rdata;
        end else if (dmi_write && dmi_addr == A_SBDATA0) begin
            sbdata0 <= dmi_wdata;
        end
    end

    // bus sequencer strobes and then waits one cycle for the memory
    always_ff @(posedge clk) begin
        if (rst) begin
            sbbusy  <= 1'b0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            sb_pend <= 1'b0;
        end else begin
            mem_req <= sb_start_wr || sb_start_rd;
            sb_pend <= mem_req;
            if (sb_start_wr || sb_start_rd) begin
                sbbusy <= 1'b1;
                mem_we <= sb_start_wr;
            end else if (sb_pend) begin
                sbbusy <= 1'b0;
            end
        end
    end

    assign mem_addr  = {2'b00, sbaddress0[31:2]};
    assign mem_wdata = sbdata0;

endmodule

// ==== dbg_mem.sv ====
`timescale 1ns/1ps

module dbg_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic           clk,
    input  logic           mem_req,
    input  logic           mem_we,
    input  dbg_pkg::addr_t mem_addr,
    input  dbg_pkg::data_t mem_wdata,
    output dbg_pkg::data_t mem_rdata
);
    import dbg_pkg::*;

    localparam int IW = $clog2(MEM_WORDS);

    data_t         mem [MEM_WORDS];
    logic [IW-1:0] idx;

    // upper word address bits alias
    assign idx = mem_addr[IW-1:0];

    always_ff @(posedge clk) begin
        if (mem_req) begin
            if (mem_we) begin
                mem[idx] <= mem_wdata;
            end else begin
                mem_rdata <= mem[idx];
            end
        end
    end

endmodule

// ==== dbg_top.sv ====
`timescale 1ns/1ps

module dbg_top #(
    parameter logic [31:0] IDCODE    = 32'h1d6a_0001,
    parameter int          MEM_WORDS = 1024
) (
    input  logic clk,
    input  logic rst,
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    output logic tdo
);
    import dbg_pkg::*;

    logic    dmi_req;
    dmaddr_t dmi_addr;
    dmi_op_t dmi_op;
    dmdata_t dmi_wdata;
    dmdata_t dmi_rdata;

    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    data_t mem_rdata;

    jtag_dtm #(
        .IDCODE (IDCODE)
    ) u_jtag_dtm (
        .clk       (clk),
        .rst       (rst),
        .tck       (tck),
        .tms       (tms),
        .tdi       (tdi),
        .tdo       (tdo),
        .dmi_req   (dmi_req),
        .dmi_addr  (dmi_addr),
        .dmi_op    (dmi_op),
        .dmi_wdata (dmi_wdata),
        .dmi_rdata (dmi_rdata)
    );

    dm_regs u_dm_regs (
        .clk       (clk),
        .rst       (rst),
        .dmi_req   (dmi_req),
        .dmi_addr  (dmi_addr),
        .dmi_op    (dmi_op),
        .dmi_wdata (dmi_wdata),
        .dmi_rdata (dmi_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    dbg_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dbg_mem (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== dbg_checker.sv ====
`timescale 1ns/1ps

module dbg_checker (
    input logic                clk,
    input logic                rst,
    input dbg_pkg::tap_state_t tap_state,
    input logic                mem_req,
    input logic                sbbusy
);
    import dbg_pkg::*;

    a_tap_reset: assert property (@(posedge clk) rst |=> tap_state == TEST_LOGIC_RESET)
        else $error("tap not in test-logic-reset after rst");

    // strobe and busy flag are set in the same cycle
    a_req_busy: assert property (@(posedge clk) disable iff (rst) mem_req |-> sbbusy)
        else $error("mem_req high while sbbusy is low");

    a_busy_end: assert property (@(posedge clk) disable iff (rst) mem_req |-> ##2 !sbbusy)
        else $error("sbbusy still high two cycles after mem_req");

endmodule

bind dbg_top dbg_checker u_dbg_checker (
    .clk       (clk),
    .rst       (rst),
    .tap_state (u_jtag_dtm.tap_state),
    .mem_req   (mem_req),
    .sbbusy    (u_dm_regs.sbbusy)
);

// ==== dbg_tb.sv ====
`timescale 1ns/1ps

module dbg_tb;
    import dbg_pkg::*;

    localparam logic [31:0] IDCODE     = 32'h1b41_f0c7;
    localparam int          MEM_WORDS  = 1024;
    localparam int          TCK_HALF   = 6;
    localparam int          SB_POLLS   = 20;
    localparam int          RAND_PAIRS = 8;
    localparam dmi_op_t     STATUS_OK  = 2'd0;

    logic   clk;
    logic   rst;
    logic   tck;
    logic   tms;
    logic   tdi;
    logic   tdo;
    ir_t    cur_ir;
    data_t  model [int];
    integer seed;

    dbg_top #(
        .IDCODE    (IDCODE),
        .MEM_WORDS (MEM_WORDS)
    ) u_dbg_top (
        .clk (clk),
        .rst (rst),
        .tck (tck),
        .tms (tms),
        .tdi (tdi),
        .tdo (tdo)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input dmi_op_t got, input dmi_op_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic int model_index(input addr_t addr);
        return int'((addr / 4) % MEM_WORDS);
    endfunction

    // one tck period with tdo sampled late in the low phase
    task automatic clock_bit(input logic tms_val, input logic tdi_val, output logic tdo_val);
        @(posedge clk);
        tck <= 1'b0;
        tms <= tms_val;
        tdi <= tdi_val;
        repeat (TCK_HALF - 1) @(posedge clk);
        @(negedge clk);
        tdo_val = tdo;
        @(posedge clk);
        tck <= 1'b1;
        repeat (TCK_HALF - 1) @(posedge clk);
    endtask

    task automatic shift_bits(input int n, input logic [63:0] din, output logic [63:0] dout);
        logic b;
        dout = '0;
        for (int i = 0; i < n; i++) begin
            // tms high on the last bit leaves the shift state
            clock_bit(i == n - 1, din[i], b);
            dout[i] = b;
        end
    endtask

    task automatic tap_reset();
        logic b;
        repeat (5) clock_bit(1'b1, 1'b0, b);
        clock_bit(1'b0, 1'b0, b);
        cur_ir = IR_IDCODE;
    endtask

    task automatic ir_scan(input ir_t ir_val);
        logic        b;
        logic [63:0] dout;
        clock_bit(1'b1, 1'b0, b);
        clock_bit(1'b1, 1'b0, b);
        clock_bit(1'b0, 1'b0, b);
        clock_bit(1'b0, 1'b0, b);
        shift_bits($bits(ir_t), 64'(ir_val), dout);
        clock_bit(1'b1, 1'b0, b);
        clock_bit(1'b0, 1'b0, b);
        cur_ir = ir_val;
    endtask

    task automatic select_ir(input ir_t ir_val);
        if (cur_ir != ir_val) begin
            ir_scan(ir_val);
        end
    endtask

    task automatic dr_scan(input int n, input logic [63:0] din, output logic [63:0] dout);
        logic b;
        clock_bit(1'b1, 1'b0, b);
        clock_bit(1'b0, 1'b0, b);
        clock_bit(1'b0, 1'b0, b);
        shift_bits(n, din, dout);
        clock_bit(1'b1, 1'b0, b);  // update-dr
        clock_bit(1'b0, 1'b0, b);
    endtask

    task automatic dmi_scan(input dmaddr_t addr, input dmdata_t data, input dmi_op_t op,
                            output dmdata_t rd, output dmi_op_t rop);
        logic [63:0] dout;
        dr_scan(W_DMI, 64'({addr, data, op}), dout);
        rop = dout[1:0];
        rd  = dout[33:2];
    endtask

    task automatic dm_read(input dmaddr_t addr, output data_t rd);
        dmi_op_t rop;
        select_ir(IR_DMI);
        dmi_scan(addr, '0, DMI_READ, rd, rop);
        check_op("dmi status", rop, STATUS_OK);
        dmi_scan(addr, '0, DMI_NOP, rd, rop);
        check_op("dmi status", rop, STATUS_OK);
    endtask

    task automatic dm_write(input dmaddr_t addr, input data_t data);
        dmdata_t rd;
        dmi_op_t rop;
        select_ir(IR_DMI);
        dmi_scan(addr, data, DMI_WRITE, rd, rop);
        check_op("dmi status", rop, STATUS_OK);
        dmi_scan(addr, '0, DMI_NOP, rd, rop);
        check_op("dmi status", rop, STATUS_OK);
    endtask

    task automatic wait_sb_idle();
        data_t sbcs;
        int    polls;
        polls = 0;
        dm_read(A_SBCS, sbcs);
        while (sbcs[21] && polls < SB_POLLS) begin
            polls++;
            dm_read(A_SBCS, sbcs);
        end
        if (sbcs[21]) begin
            $display("ERROR at %0t: sbbusy still set after %0d polls", $time, SB_POLLS);
            abort_run();
        end
    endtask

    task automatic sb_write(input addr_t addr, input data_t data);
        dm_write(A_SBADDRESS0, addr);
        wait_sb_idle();
        dm_write(A_SBDATA0, data);
        wait_sb_idle();
        model[model_index(addr)] = data;
    endtask

    // sbreadonaddr is set, so the address write starts the read
    task automatic sb_read(input addr_t addr, output data_t rd);
        dm_write(A_SBADDRESS0, addr);
        wait_sb_idle();
        dm_read(A_SBDATA0, rd);
    endtask

    task automatic check_model(input addr_t addr, input data_t got);
        if (!model.exists(model_index(addr))) begin
            $display("ERROR at %0t: read of %h hits a word that was never written", $time, addr);
            abort_run();
        end else begin
            check_data("sbdata0 vs model", got, model[model_index(addr)]);
        end
    endtask

    task automatic read_hex(input int fd, output logic [31:0] val);
        if ($fscanf(fd, "%h", val) != 1) begin
            $display("ERROR: pattern file has a missing or bad hex operand");
            abort_run();
        end
    endtask

    task automatic run_patterns();
        int                 fd;
        int                 code;
        int                 cmds;
        logic [8*8-1:0]     tok;
        logic [8*128-1:0]   rest;
        logic [31:0]        a;
        logic [31:0]        b;
        data_t              rd;
        logic [63:0]        dout;
        cmds = 0;
        fd = $fopen("dbg_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open dbg_patterns.txt");
            abort_run();
        end else begin
            code = $fscanf(fd, "%s", tok);
            while (code == 1) begin
                case (tok)
                    "#": begin
                        void'($fgets(rest, fd));
                    end
                    "I": begin
                        read_hex(fd, a);
                        tap_reset();
                        dr_scan(32, '0, dout);
                        check_data("idcode after reset", dout[31:0], a);
                        ir_scan(IR_IDCODE);
                        dr_scan(32, '0, dout);
                        check_data("idcode", dout[31:0], a);
                    end
                    "C": begin
                        read_hex(fd, a);
                        ir_scan(IR_DTMCS);
                        dr_scan(32, '0, dout);
                        check_data("dtmcs", dout[31:0], a);
                    end
                    "B": begin
                        read_hex(fd, a);
                        ir_scan(IR_BYPASS);
                        dr_scan(33, 64'(a), dout);
                        check_data("bypass first bit", data_t'(dout[0]), '0);
                        check_data("bypass", dout[32:1], a);
                    end
                    "W": begin
                        read_hex(fd, a);
                        read_hex(fd, b);
                        dm_write(dmaddr_t'(a), b);
                    end
                    "Q": begin
                        read_hex(fd, a);
                        read_hex(fd, b);
                        dm_read(dmaddr_t'(a), rd);
                        check_data($sformatf("dm reg %02h", a[6:0]), rd, b);
                    end
                    "S": begin
                        read_hex(fd, a);
                        read_hex(fd, b);
                        sb_write(a, b);
                    end
                    "R": begin
                        read_hex(fd, a);
                        read_hex(fd, b);
                        sb_read(a, rd);
                        check_data("sbdata0", rd, b);
                        check_model(a, rd);
                    end
                    default: begin
                        $display("ERROR: unknown command in pattern file after %0d commands",
                                 cmds);
                        abort_run();
                    end
                endcase
                if (tok != "#") begin
                    cmds++;
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        if (cmds == 0) begin
            $display("ERROR: no commands read from dbg_patterns.txt");
            abort_run();
        end
    endtask

    task automatic run_random();
        addr_t      addr;
        addr_t      alias_addr;
        addr_t      other_addr;
        data_t      data;
        data_t      rd;
        logic [3:0] k;
        for (int i = 0; i < RAND_PAIRS; i++) begin
            addr = $random(seed);
            addr[1:0] = 2'b00;
            data = $random(seed);
            k = 4'($random(seed));
            // same word index with different upper bits
            alias_addr = addr + (addr_t'(k) + 32'd1) * addr_t'(MEM_WORDS * 4);
            // neighbouring word holds the inverse so each read changes sbdata0
            other_addr = addr ^ 32'h4;
            sb_write(addr, data);
            sb_write(other_addr, ~data);
            sb_read(alias_addr, rd);
            check_model(alias_addr, rd);
            sb_read(other_addr, rd);
            check_model(other_addr, rd);
            sb_read(addr, rd);
            check_model(addr, rd);
        end
    endtask

    initial begin
        rst    = 1'b1;
        tck    = 1'b0;
        tms    = 1'b1;
        tdi    = 1'b0;
        seed   = 32'hdacf4c3d;
        cur_ir = IR_IDCODE;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        tap_reset();
        dm_write(A_SBCS, 32'h0010_0000);
        run_patterns();
        run_random();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== dbg_patterns.txt ====
# columns: command, then hex operands. I idcode, C dtmcs, B bypass word,
# W/Q dm addr and data, S/R bus byte addr and data (Q and R compare data)
I 1b41f0c7
C 00001071
B a5c3e10f
B 00000001
W 00000010 ffffffff
Q 00000010 03ffffc1
W 00000010 02468ac1
Q 00000010 02468ac1
Q 00000011 00000002
Q 00000020 00000000
Q 00000038 20140000
S 00000000 deadbeef
R 00000000 deadbeef
S 00000044 12345678
R 00000044 12345678
S 00000ffc cafef00d
R 00000ffc cafef00d
S 00003100 0badc0de
R 00000100 0badc0de
R 80000100 0badc0de

// ==== files.f ====
dbg_pkg.sv
jtag_dtm.sv
dm_regs.sv
dbg_mem.sv
dbg_top.sv
dbg_checker.sv
dbg_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dbg_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
